/* logic/exec_pkg.sv */
`default_nettype none

package exec_pkg;

  typedef logic [31:0] word_t;      // PC, operands, results and bus data.
  typedef logic [5:0]  op_t;        // Decoded operation code.
  typedef logic [4:0]  reg_addr_t;  // Destination register index.
  typedef logic [19:0] boffset_t;   // Branch offset handed to fetch.
  typedef logic [3:0]  sel_t;       // Wishbone byte lanes.

  // Immediate forms reuse the register form. The immediate sits in param2.
  localparam op_t OP_LUI   = 6'd0;
  localparam op_t OP_AUIPC = 6'd1;
  localparam op_t OP_JAL   = 6'd2;
  localparam op_t OP_JALR  = 6'd3;
  localparam op_t OP_ADD   = 6'd4;
  localparam op_t OP_SUB   = 6'd5;
  localparam op_t OP_XOR   = 6'd6;
  localparam op_t OP_OR    = 6'd7;
  localparam op_t OP_AND   = 6'd8;
  localparam op_t OP_SLT   = 6'd9;
  localparam op_t OP_SLTU  = 6'd10;
  localparam op_t OP_SLL   = 6'd11;
  localparam op_t OP_SRL   = 6'd12;
  localparam op_t OP_SRA   = 6'd13;
  localparam op_t OP_LB    = 6'd14;
  localparam op_t OP_LH    = 6'd15;
  localparam op_t OP_LW    = 6'd16;
  localparam op_t OP_LBU   = 6'd17;
  localparam op_t OP_LHU   = 6'd18;
  localparam op_t OP_SB    = 6'd19;
  localparam op_t OP_SH    = 6'd20;
  localparam op_t OP_SW    = 6'd21;
  localparam op_t OP_BEQ   = 6'd22;
  localparam op_t OP_BNE   = 6'd23;
  localparam op_t OP_BLT   = 6'd24;
  localparam op_t OP_BGE   = 6'd25;
  localparam op_t OP_BLTU  = 6'd26;
  localparam op_t OP_BGEU  = 6'd27;

  typedef struct packed {
    word_t     pc;
    op_t       op;
    word_t     param1;  // First operand, base address for memory ops.
    word_t     param2;  // Second operand or immediate.
    word_t     param3;  // Store data, or branch offset in bits 19:0.
    reg_addr_t rd;
  } exec_req_t;

  typedef struct packed {
    logic      result_write;  // Low for stores and branches.
    reg_addr_t result_addr;
    word_t     result;
    logic      branch;        // Jump or taken branch.
    boffset_t  boffset;       // Zero unless branch is set.
  } exec_resp_t;

  typedef struct packed {
    word_t adr;
    word_t dat;
    logic  we;
    sel_t  sel;
    logic  stb;
    logic  cyc;
  } wb_req_t;

endpackage

`default_nettype wire

/* logic/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
  input  exec_pkg::op_t   op_i,
  input  exec_pkg::word_t pc_i,
  input  exec_pkg::word_t a_i,
  input  exec_pkg::word_t b_i,
  output exec_pkg::word_t result_o,
  output exec_pkg::word_t sum_o,
  output logic            taken_o
);
  import exec_pkg::*;

  logic eq;
  logic lt_s;
  logic lt_u;

  assign sum_o = a_i + b_i;                   // Also the load/store address.
  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);

  always_comb begin
    case (op_i)
      OP_LUI:          result_o = b_i;            // Upper immediate prepared by decode.
      OP_AUIPC:        result_o = pc_i + b_i;
      OP_JAL, OP_JALR: result_o = pc_i + 32'd4;   // Link address.
      OP_ADD:          result_o = sum_o;
      OP_SUB:          result_o = a_i - b_i;
      OP_XOR:          result_o = a_i ^ b_i;
      OP_OR:           result_o = a_i | b_i;
      OP_AND:          result_o = a_i & b_i;
      OP_SLT:          result_o = {31'b0, lt_s};
      OP_SLTU:         result_o = {31'b0, lt_u};
      default:         result_o = '0;             // Shifts, memory and branches.
    endcase
  end

  // Branch decision. Jumps always redirect.
  always_comb begin
    case (op_i)
      OP_JAL, OP_JALR: taken_o = 1'b1;
      OP_BEQ:          taken_o = eq;
      OP_BNE:          taken_o = !eq;
      OP_BLT:          taken_o = lt_s;
      OP_BGE:          taken_o = !lt_s;
      OP_BLTU:         taken_o = lt_u;
      OP_BGEU:         taken_o = !lt_u;
      default:         taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/exec_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_shifter (
  input  exec_pkg::op_t   op_i,
  input  exec_pkg::word_t data_i,
  input  logic [4:0]      shamt_i,
  output exec_pkg::word_t result_o
);
  import exec_pkg::*;

  logic  left;
  logic  arith;
  word_t data_rev;
  word_t data;
  word_t s1, s2, s3, s4, s5;
  word_t mask;
  word_t fill;
  word_t shifted;
  word_t shifted_rev;

  assign left     = (op_i == OP_SLL);
  assign arith    = (op_i == OP_SRA);
  assign data_rev = {<<{data_i}};             // Left shift runs as a right shift.
  assign data     = left ? data_rev : data_i;

  // Rotate right by 1, 2, 4, 8 and 16.
  assign s1 = shamt_i[0] ? {data[0],    data[31:1]}  : data;
  assign s2 = shamt_i[1] ? {s1[1:0],    s1[31:2]}    : s1;
  assign s3 = shamt_i[2] ? {s2[3:0],    s2[31:4]}    : s2;
  assign s4 = shamt_i[3] ? {s3[7:0],    s3[31:8]}    : s3;
  assign s5 = shamt_i[4] ? {s4[15:0],   s4[31:16]}   : s4;

  assign mask = 32'hffff_ffff >> shamt_i;     // Ones over the bits kept.
  assign fill = arith ? {32{data_i[31]}} : '0; // Sign fill only for SRA.

  assign shifted     = (s5 & mask) | (fill & ~mask);
  assign shifted_rev = {<<{shifted}};
  assign result_o    = left ? shifted_rev : shifted;

endmodule

`default_nettype wire

/* logic/exec_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_lsu (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              start_i,
  input  exec_pkg::op_t     op_i,
  input  exec_pkg::word_t   addr_i,
  input  exec_pkg::word_t   store_data_i,
  input  exec_pkg::word_t   wb_dat_i,
  input  logic              wb_ack_i,
  output exec_pkg::wb_req_t wb_o,
  output logic              done_o,
  output exec_pkg::word_t   load_data_o
);
  import exec_pkg::*;

  typedef enum logic [1:0] {IDLE, REQUEST, DONE} state_t;

  state_t      state_q;
  op_t         op_q;
  word_t       adr_q;
  word_t       dat_q;
  sel_t        sel_q;
  sel_t        sel_d;
  word_t       dat_d;
  word_t       load_q;
  word_t       load_d;
  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  // Byte lanes from access size and low address bits.
  always_comb begin
    case (op_i)
      OP_LB, OP_LBU, OP_SB: sel_d = 4'b0001 << addr_i[1:0];
      OP_LH, OP_LHU, OP_SH: sel_d = addr_i[1] ? 4'b1100 : 4'b0011;
      default:              sel_d = 4'b1111;     // LW and SW.
    endcase
  end

  // Store data copied into every lane.
  always_comb begin
    case (op_i)
      OP_SB:   dat_d = {4{store_data_i[7:0]}};
      OP_SH:   dat_d = {2{store_data_i[15:0]}};
      default: dat_d = store_data_i;
    endcase
  end

  // Pick the addressed lane of the read word.
  always_comb begin
    case (adr_q[1:0])
      2'd0:    lane_b = wb_dat_i[7:0];
      2'd1:    lane_b = wb_dat_i[15:8];
      2'd2:    lane_b = wb_dat_i[23:16];
      default: lane_b = wb_dat_i[31:24];
    endcase
    lane_h = adr_q[1] ? wb_dat_i[31:16] : wb_dat_i[15:0];
    case (op_q)
      OP_LB:   load_d = {{24{lane_b[7]}}, lane_b};   // Sign extend.
      OP_LBU:  load_d = {24'b0, lane_b};
      OP_LH:   load_d = {{16{lane_h[15]}}, lane_h};
      OP_LHU:  load_d = {16'b0, lane_h};
      default: load_d = wb_dat_i;                    // Word load. Stores ignore it.
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= REQUEST;
          end
        end
        REQUEST: begin
          if (wb_ack_i) begin
            state_q <= DONE;                         // Cycle ends on ack.
          end
        end
        default: state_q <= IDLE;                    // DONE lasts one cycle.
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      op_q  <= op_i;
      adr_q <= addr_i;
      dat_q <= dat_d;
      sel_q <= sel_d;
    end
    if (state_q == REQUEST && wb_ack_i) begin
      load_q <= load_d;
    end
  end

  always_comb begin
    wb_o.adr = adr_q;                                // Byte address. Sel marks the lanes.
    wb_o.dat = dat_q;
    wb_o.we  = (op_q == OP_SB) || (op_q == OP_SH) || (op_q == OP_SW);
    wb_o.sel = sel_q;
    wb_o.stb = (state_q == REQUEST);
    wb_o.cyc = (state_q == REQUEST);
  end

  assign done_o      = (state_q == DONE);
  assign load_data_o = load_q;

endmodule

`default_nettype wire

/* logic/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_valid_i,
  input  exec_pkg::exec_req_t  req_i,
  input  logic                 resp_ready_i,
  input  exec_pkg::word_t      alu_result_i,
  input  exec_pkg::word_t      shift_result_i,
  input  logic                 taken_i,
  input  logic                 mem_done_i,
  input  exec_pkg::word_t      load_data_i,
  output logic                 req_ready_o,
  output logic                 resp_valid_o,
  output exec_pkg::exec_resp_t resp_o,
  output exec_pkg::op_t        op_o,
  output exec_pkg::word_t      pc_o,
  output exec_pkg::word_t      a_o,
  output exec_pkg::word_t      b_o,
  output logic                 mem_start_o,
  output exec_pkg::word_t      store_data_o
);
  import exec_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM, S_RESP} state_t;

  state_t     state_q;
  state_t     state_d;
  exec_req_t  req_q;
  exec_resp_t resp_q;
  exec_resp_t resp_d;
  logic       is_shift;
  logic       is_load;
  logic       is_store;
  logic       is_branch;
  logic       is_mem;
  logic       accept;
  logic       resp_load;

  // Op classes of the held request.
  assign is_shift  = req_q.op inside {OP_SLL, OP_SRL, OP_SRA};
  assign is_load   = req_q.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
  assign is_store  = req_q.op inside {OP_SB, OP_SH, OP_SW};
  assign is_branch = req_q.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  assign is_mem    = is_load || is_store;

  // Ready when idle, or when the held response leaves this cycle.
  assign req_ready_o  = (state_q == S_IDLE) || (state_q == S_RESP && resp_ready_i);
  assign accept       = req_valid_i && req_ready_o;
  assign resp_valid_o = (state_q == S_RESP);
  assign mem_start_o  = (state_q == S_EXEC) && is_mem;  // One-cycle pulse.
  assign resp_load    = (state_q == S_EXEC && !is_mem) || (state_q == S_MEM && mem_done_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) begin
          state_d = S_EXEC;
        end
      end
      S_EXEC: state_d = is_mem ? S_MEM : S_RESP;
      S_MEM: begin
        if (mem_done_i) begin
          state_d = S_RESP;
        end
      end
      default: begin
        if (accept) begin
          state_d = S_EXEC;                             // Back-to-back issue.
        end else if (resp_ready_i) begin
          state_d = S_IDLE;
        end
      end
    endcase
  end

  // Response of the held request.
  always_comb begin
    resp_d.result_write = !(is_store || is_branch);
    resp_d.result_addr  = req_q.rd;
    if (is_load) begin
      resp_d.result = load_data_i;
    end else if (is_shift) begin
      resp_d.result = shift_result_i;
    end else begin
      resp_d.result = alu_result_i;
    end
    resp_d.branch  = taken_i;                           // Jumps and taken branches.
    resp_d.boffset = taken_i ? req_q.param3[19:0] : '0;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (resp_load) begin
      resp_q <= resp_d;                                 // Held until taken.
    end
  end

  assign resp_o       = resp_q;
  assign op_o         = req_q.op;
  assign pc_o         = req_q.pc;
  assign a_o          = req_q.param1;
  assign b_o          = req_q.param2;
  assign store_data_o = req_q.param3;

endmodule

`default_nettype wire

/* logic/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  exec_pkg::exec_req_t  req_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output exec_pkg::exec_resp_t resp_o,
  output exec_pkg::wb_req_t    wb_o,
  input  exec_pkg::word_t      wb_dat_i,
  input  logic                 wb_ack_i
);
  import exec_pkg::*;

  op_t   op;
  word_t pc;
  word_t a;
  word_t b;
  word_t alu_result;
  word_t sum;                                   // Memory address.
  word_t shift_result;
  word_t store_data;
  word_t load_data;
  logic  taken;
  logic  mem_start;
  logic  mem_done;

  exec_ctrl i_exec_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .resp_ready_i   (resp_ready_i),
    .alu_result_i   (alu_result),
    .shift_result_i (shift_result),
    .taken_i        (taken),
    .mem_done_i     (mem_done),
    .load_data_i    (load_data),
    .req_ready_o    (req_ready_o),
    .resp_valid_o   (resp_valid_o),
    .resp_o         (resp_o),
    .op_o           (op),
    .pc_o           (pc),
    .a_o            (a),
    .b_o            (b),
    .mem_start_o    (mem_start),
    .store_data_o   (store_data)
  );

  exec_alu i_exec_alu (
    .op_i     (op),
    .pc_i     (pc),
    .a_i      (a),
    .b_i      (b),
    .result_o (alu_result),
    .sum_o    (sum),
    .taken_o  (taken)
  );

  exec_shifter i_exec_shifter (
    .op_i     (op),
    .data_i   (a),
    .shamt_i  (b[4:0]),                         // Upper amount bits ignored.
    .result_o (shift_result)
  );

  exec_lsu i_exec_lsu (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (mem_start),
    .op_i         (op),
    .addr_i       (sum),
    .store_data_i (store_data),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .wb_o         (wb_o),
    .done_o       (mem_done),
    .load_data_o  (load_data)
  );

endmodule

`default_nettype wire

/* dv/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_tb;
  import exec_pkg::*;

  logic        clk = 1'b0;
  logic        rst;
  logic        req_valid;
  logic        req_ready;
  exec_req_t   req;
  logic        resp_valid;
  logic        resp_ready;
  exec_resp_t  resp;
  wb_req_t     wb;
  word_t       wb_dat;
  logic        wb_ack;

  logic [31:0] lfsr_q = 32'hd9c8a8a9;
  word_t       mem [64];       // Memory behind the bus.
  word_t       ref_mem [64];   // Model copy of the same memory.
  exec_resp_t  exp_q [$];      // Expected responses in issue order.
  wb_req_t     bus_q [$];      // Expected bus cycles in issue order.
  exec_resp_t  held;
  logic        held_valid;
  logic        req_fire;
  logic        bus_active;
  logic [1:0]  ack_wait;
  int          issued;
  int          stall;

  exec_top i_exec_top (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_o       (resp),
    .wb_o         (wb),
    .wb_dat_i     (wb_dat),
    .wb_ack_i     (wb_ack)
  );

  always #2 clk = ~clk;  // 4 ns period.

  // Taps 32, 22, 2, 1. One step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic word_t rand_word();
    case (rand_bits(3))
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'h7fff_ffff;   // Signed edges.
      3:       return 32'h8000_0000;
      4:       return 32'hffff_ffff;
      default: return rand_bits(32);
    endcase
  endfunction

  function automatic word_t merge_lanes(input word_t old, input word_t dat, input sel_t sel);
    word_t w;
    int    k;
    w = old;
    for (k = 0; k < 4; k++) begin
      if (sel[k]) w[8*k +: 8] = dat[8*k +: 8];
    end
    return w;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_resp(input string name, input exec_resp_t got, input exec_resp_t exp);
    exec_resp_t g;
    exec_resp_t e;
    g = got;
    e = exp;
    if (!exp.result_write) begin     // Result fields unused without a register write.
      g.result      = '0;
      g.result_addr = '0;
      e.result      = '0;
      e.result_addr = '0;
    end
    if (g !== e) stop_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) stop_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_sel(input string name, input sel_t got, input sel_t exp);
    if (got !== exp) stop_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) stop_run($sformatf("error %s: got %h expected %h", name, got, exp));
  endtask

  // Reference model. Pushes the expected response and bus cycle.
  task automatic model_op(input exec_req_t r);
    exec_resp_t e;
    wb_req_t    b;
    word_t      addr;
    word_t      w;
    logic [4:0] amt;
    logic [1:0] off;
    logic [5:0] idx;
    addr = r.param1 + r.param2;
    idx  = addr[7:2];
    off  = addr[1:0];
    w    = ref_mem[idx] >> {off, 3'b000};   // Addressed bytes moved down.
    amt  = r.param2[4:0];
    e    = '0;
    e.result_write = 1'b1;
    e.result_addr  = r.rd;
    b     = '0;
    b.adr = addr;
    b.cyc = 1'b1;
    b.stb = 1'b1;
    b.sel = 4'b1111;
    case (r.op)
      OP_LUI:          e.result = r.param2;
      OP_AUIPC:        e.result = r.pc + r.param2;
      OP_JAL, OP_JALR: begin
        e.result = r.pc + 32'd4;
        e.branch = 1'b1;
      end
      OP_ADD:  e.result = r.param1 + r.param2;
      OP_SUB:  e.result = r.param1 - r.param2;
      OP_XOR:  e.result = r.param1 ^ r.param2;
      OP_OR:   e.result = r.param1 | r.param2;
      OP_AND:  e.result = r.param1 & r.param2;
      OP_SLT:  e.result = {31'b0, ($signed(r.param1) < $signed(r.param2))};
      OP_SLTU: e.result = {31'b0, (r.param1 < r.param2)};
      OP_SLL:  e.result = r.param1 << amt;
      OP_SRL:  e.result = r.param1 >> amt;
      OP_SRA:  e.result = $signed(r.param1) >>> amt;
      OP_LB:   e.result = {{24{w[7]}}, w[7:0]};
      OP_LBU:  e.result = {24'b0, w[7:0]};
      OP_LH:   e.result = {{16{w[15]}}, w[15:0]};
      OP_LHU:  e.result = {16'b0, w[15:0]};
      OP_LW:   e.result = w;
      OP_BEQ:  e.branch = (r.param1 == r.param2);
      OP_BNE:  e.branch = (r.param1 != r.param2);
      OP_BLT:  e.branch = ($signed(r.param1) < $signed(r.param2));
      OP_BGE:  e.branch = ($signed(r.param1) >= $signed(r.param2));
      OP_BLTU: e.branch = (r.param1 < r.param2);
      OP_BGEU: e.branch = (r.param1 >= r.param2);
      default: ;                             // Stores handled below.
    endcase
    if (r.op inside {OP_LB, OP_LBU, OP_SB}) b.sel = 4'b0001 << off;
    if (r.op inside {OP_LH, OP_LHU, OP_SH}) b.sel = 4'b0011 << off;
    case (r.op)
      OP_SB:   b.dat = {4{r.param3[7:0]}};
      OP_SH:   b.dat = {2{r.param3[15:0]}};
      default: b.dat = r.param3;
    endcase
    if (r.op inside {OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}) begin
      e.result_write = 1'b0;
    end
    if (e.branch) e.boffset = r.param3[19:0];
    exp_q.push_back(e);
    if (r.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW}) begin
      b.we = r.op inside {OP_SB, OP_SH, OP_SW};
      if (b.we) ref_mem[idx] = merge_lanes(ref_mem[idx], b.dat, b.sel);
      bus_q.push_back(b);
    end
  endtask

  task automatic new_request(output exec_req_t r);
    word_t target;
    r.pc     = rand_bits(30) << 2;
    r.op     = 6'(rand_bits(5) % 28);
    r.param1 = rand_word();
    r.param2 = rand_word();
    r.param3 = rand_bits(32);
    r.rd     = 5'(rand_bits(5));
    if (r.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU} && rand_bits(2) == 0) begin
      r.param2 = r.param1;                   // Equal operands.
    end
    if (r.op inside {OP_SLL, OP_SRL, OP_SRA}) begin
      case (rand_bits(2))
        0:       r.param2[4:0] = 5'd0;
        1:       r.param2[4:0] = 5'd31;
        default: ;
      endcase
    end
    if (r.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW}) begin
      target = rand_bits(6) << 2;            // Aligned, inside the 64 words.
      if (r.op inside {OP_LB, OP_LBU, OP_SB}) target = target | rand_bits(2);
      if (r.op inside {OP_LH, OP_LHU, OP_SH}) target = target | (rand_bits(1) << 1);
      r.param2 = target - r.param1;
    end
  endtask

  // Wishbone slave. Checks each new cycle and acks after 0 to 3 waits.
  task automatic drive_bus();
    wb_req_t exp;
    if (!wb.cyc) begin
      wb_ack     = 1'b0;
      wb_dat     = rand_bits(32);            // Garbage outside ack.
      bus_active = 1'b0;
      if (wb.stb) stop_run("stb is high while cyc is low");
    end else if (!bus_active) begin
      bus_active = 1'b1;
      if (bus_q.size() == 0) stop_run("Wishbone cycle started with no memory op outstanding");
      exp = bus_q.pop_front();
      check_bit("wb_o.stb", wb.stb, 1'b1);
      check_word("wb_o.adr", wb.adr, exp.adr);
      check_bit("wb_o.we", wb.we, exp.we);
      check_sel("wb_o.sel", wb.sel, exp.sel);
      if (exp.we) check_word("wb_o.dat", wb.dat, exp.dat);
      ack_wait = 2'(rand_bits(2));
    end
    if (wb.cyc && !wb_ack) begin
      if (ack_wait == 2'd0) begin
        wb_ack = 1'b1;
        wb_dat = mem[wb.adr[7:2]];
        if (wb.we) mem[wb.adr[7:2]] = merge_lanes(mem[wb.adr[7:2]], wb.dat, wb.sel);
      end else begin
        ack_wait = ack_wait - 2'd1;
      end
    end
  endtask

  // Samples 1 ns before the edge, then drives 1 ns after it.
  task automatic run_cycle();
    exec_resp_t exp;
    exec_req_t  r;
    #2;
    if (held_valid && !resp_valid) stop_run("resp_valid_o dropped before the response was taken");
    if (resp_valid && held_valid) check_resp("resp_o held", resp, held);
    if (resp_valid && !resp_ready) check_bit("req_ready_o", req_ready, 1'b0);
    req_fire = req_valid && req_ready;
    if (resp_valid && resp_ready) begin
      if (exp_q.size() == 0) stop_run("response arrived with no request outstanding");
      exp        = exp_q.pop_front();
      check_resp("resp_o", resp, exp);
      held_valid = 1'b0;
      stall      = 0;
    end else begin
      held_valid = resp_valid;
      held       = resp;
      if (exp_q.size() != 0) stall++;
      if (stall > 40) stop_run("timeout waiting for a response");
    end
    @(posedge clk);
    #1;
    drive_bus();
    resp_ready = (rand_bits(2) != 0);        // Stall about one cycle in four.
    if (req_fire || !req_valid) begin
      req_valid = 1'b0;
      if (issued < 600 && rand_bits(2) != 0) begin
        new_request(r);
        model_op(r);
        req       = r;
        req_valid = 1'b1;
        issued++;
      end
    end
  endtask

  initial begin
    int         cycles;
    int         i;
    logic [7:0] ib;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b0;
    wb_dat     = '0;
    wb_ack     = 1'b0;
    held       = '0;
    held_valid = 1'b0;
    req_fire   = 1'b0;
    bus_active = 1'b0;
    ack_wait   = 2'd0;
    issued     = 0;
    stall      = 0;
    for (i = 0; i < 64; i++) begin
      ib         = i[7:0];
      mem[i]     = {ib ^ 8'h3c, ib * 8'd7, ~ib, ib + 8'h81};
      ref_mem[i] = mem[i];
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    #2;
    check_bit("resp_valid_o", resp_valid, 1'b0);   // Idle after reset.
    check_bit("wb_o.cyc", wb.cyc, 1'b0);
    check_bit("wb_o.stb", wb.stb, 1'b0);
    check_bit("req_ready_o", req_ready, 1'b1);
    @(posedge clk);
    #1;
    cycles = 0;
    while ((issued < 600 || exp_q.size() != 0) && cycles < 20000) begin
      run_cycle();
      cycles++;
    end
    if (issued == 600 && exp_q.size() == 0 && bus_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_run("timeout: the run did not finish within the cycle limit");
    end
  end

endmodule

`default_nettype wire

/* compile.f */
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_shifter.sv
logic/exec_lsu.sv
logic/exec_ctrl.sv
logic/exec_top.sv
dv/exec_tb.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing
TOP      ?= exec_tb
FILELIST ?= compile.f
BUILD    ?= obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
